/* Makefile */
# Verilator flow for the host control core

VERILATOR ?= verilator
TOP       ?= tb_bh_ctrl
RTL_TOP   ?= bh_ctrl_top
FILELIST  ?= bh_ctrl_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
PASS_MSG  := STATUS: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) hdl/bh_ctrl_settings.svh tests/bh_ctrl_input.txt

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bh_ctrl_top.f */
+incdir+hdl
hdl/bh_ctrl_pkg.sv
hdl/host_cmd_fsm.sv
hdl/workload_config_regs.sv
hdl/status_readback.sv
hdl/bh_ctrl_top.sv
tests/bh_ctrl_props.sv
tests/tb_bh_ctrl.sv

/* hdl/bh_ctrl_pkg.sv */
package bh_ctrl_pkg;

    `include "bh_ctrl_settings.svh"

    // host fsm states, codes are shown on the LEDs and the state word
    typedef enum logic [3:0] {
        ST_IDLE                 = 4'd0,
        ST_WORKLOAD_CONFIG      = 4'd1,
        ST_CONFIG_DONE          = 4'd2,
        ST_DRAMFILL_WEIGHT      = 4'd3,
        ST_DRAMFILL_WEIGHT_DONE = 4'd4,
        ST_DRAMFILL_INFERENCE   = 4'd5,
        ST_DRAMFILL_TRAINING    = 4'd6,
        ST_ASIC_CONFIG          = 4'd7,
        ST_ASIC_CONFIG_DONE     = 4'd8,
        ST_ASIC_INFERENCE       = 4'd9,
        ST_ASIC_TRAINING        = 4'd10
    } host_state_e;

    // command values qualified by trigger bit 0
    typedef enum logic [`CMD_W-1:0] {
        CMD_ENTER_CONFIG = 32'd1,
        CMD_CONFIG_DONE  = 32'd2,
        CMD_WEIGHT_FILL  = 32'd3,
        CMD_ASIC_CONFIG  = 32'd7
    } host_cmd_e;

    // trigger bit that loads a field, also its readback select
    typedef enum logic [3:0] {
        FLD_ASIC_MODE   = 4'd1,
        FLD_TRAIN_EPOCH = 4'd2,
        FLD_INFER_EPOCH = 4'd3,
        FLD_DATASET     = 4'd4,
        FLD_TIMESTEPS   = 4'd5,
        FLD_INPUT_SIZE  = 4'd6,
        FLD_LONG_STREAM = 4'd7,
        FLD_BINARY_CLS  = 4'd8,
        FLD_LOSER_ENC   = 4'd9,
        FLD_L1_CUT      = 4'd10,
        FLD_L2_CUT      = 4'd11
    } cfg_field_e;

endpackage

/* hdl/bh_ctrl_settings.svh */
`ifndef BH_CTRL_SETTINGS_SVH
`define BH_CTRL_SETTINGS_SVH

// host command word and readback word
`define CMD_W 32
// trigger strobe vector
`define TRIG_W 32
// epoch, timestep and input-size fields
`define EPOCH_W 16
// cut list entry widths
`define L1_CUT_W 17
`define L2_CUT_W 16
`define CUT_DEPTH 15
`define CUT_IDX_W 4
`define LED_W 8
// cycles per blink half-period, board value is 50400000
`define BLINK_HALF_PERIOD 8

`endif

/* hdl/bh_ctrl_top.sv */
`timescale 1ns/1ps

`include "bh_ctrl_settings.svh"

module bh_ctrl_top
    import bh_ctrl_pkg::*;
(
    input  logic               okClk,
    input  logic               reset_n,
    input  logic [`CMD_W-1:0]  cmd_word,
    input  logic [`TRIG_W-1:0] trig,
    output logic [`CMD_W-1:0]  readback,
    output logic [`CMD_W-1:0]  state_word,
    output logic [`LED_W-1:0]  led
);

    host_state_e                     state;
    logic [1:0]                      asic_mode;
    logic [`EPOCH_W-1:0]             training_epochs;
    logic [`EPOCH_W-1:0]             inference_epochs;
    logic [1:0]                      dataset;
    logic [`EPOCH_W-1:0]             timesteps;
    logic [`EPOCH_W-1:0]             input_size;
    logic                            long_stream;
    logic                            binary_cls;
    logic                            loser_enc;
    logic [`CUT_DEPTH*`L1_CUT_W-1:0] l1_cut_list;
    logic [`CUT_DEPTH*`L2_CUT_W-1:0] l2_cut_list;
    logic [`CUT_IDX_W-1:0]           cut_last;

    // host sees the raw state code
    assign state_word = `CMD_W'(state);

    host_cmd_fsm u_fsm (
        .okClk    (okClk),
        .reset_n  (reset_n),
        .cmd_word (cmd_word),
        .trig     (trig),
        .state    (state)
    );

    workload_config_regs u_cfg (
        .okClk            (okClk),
        .reset_n          (reset_n),
        .cmd_word         (cmd_word),
        .trig             (trig),
        .state            (state),
        .asic_mode        (asic_mode),
        .training_epochs  (training_epochs),
        .inference_epochs (inference_epochs),
        .dataset          (dataset),
        .timesteps        (timesteps),
        .input_size       (input_size),
        .long_stream      (long_stream),
        .binary_cls       (binary_cls),
        .loser_enc        (loser_enc),
        .l1_cut_list      (l1_cut_list),
        .l2_cut_list      (l2_cut_list),
        .cut_last         (cut_last)
    );

    status_readback u_rb (
        .okClk            (okClk),
        .reset_n          (reset_n),
        .state            (state),
        .cmd_word         (cmd_word),
        .asic_mode        (asic_mode),
        .training_epochs  (training_epochs),
        .inference_epochs (inference_epochs),
        .dataset          (dataset),
        .timesteps        (timesteps),
        .input_size       (input_size),
        .long_stream      (long_stream),
        .binary_cls       (binary_cls),
        .loser_enc        (loser_enc),
        .l1_cut_list      (l1_cut_list),
        .l2_cut_list      (l2_cut_list),
        .cut_last         (cut_last),
        .readback         (readback),
        .led              (led)
    );

endmodule

/* hdl/host_cmd_fsm.sv */
`timescale 1ns/1ps

`include "bh_ctrl_settings.svh"

module host_cmd_fsm
    import bh_ctrl_pkg::*;
(
    input  logic               okClk,
    input  logic               reset_n,
    input  logic [`CMD_W-1:0]  cmd_word,
    input  logic [`TRIG_W-1:0] trig,
    output host_state_e        state
);

    host_state_e state_next;

    // bit 0 is the state step strobe, cmd_word says where to go
    always_comb begin
        state_next = state;
        if (trig[0]) begin
            case (state)
                ST_IDLE: begin
                    if (cmd_word == CMD_ENTER_CONFIG) begin
                        state_next = ST_WORKLOAD_CONFIG;
                    end
                end
                ST_WORKLOAD_CONFIG: begin
                    if (cmd_word == CMD_CONFIG_DONE) begin
                        state_next = ST_CONFIG_DONE;
                    end
                end
                ST_CONFIG_DONE: begin
                    // two branches out of config done
                    if (cmd_word == CMD_WEIGHT_FILL) begin
                        state_next = ST_DRAMFILL_WEIGHT;
                    end else if (cmd_word == CMD_ASIC_CONFIG) begin
                        state_next = ST_ASIC_CONFIG;
                    end
                end
                // later states have no exits yet
                default: begin
                    state_next = state;
                end
            endcase
        end
    end

    always_ff @(posedge okClk) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* hdl/status_readback.sv */
`timescale 1ns/1ps

`include "bh_ctrl_settings.svh"

module status_readback
    import bh_ctrl_pkg::*;
(
    input  logic                               okClk,
    input  logic                               reset_n,
    input  host_state_e                        state,
    input  logic [`CMD_W-1:0]                  cmd_word,
    input  logic [1:0]                         asic_mode,
    input  logic [`EPOCH_W-1:0]                training_epochs,
    input  logic [`EPOCH_W-1:0]                inference_epochs,
    input  logic [1:0]                         dataset,
    input  logic [`EPOCH_W-1:0]                timesteps,
    input  logic [`EPOCH_W-1:0]                input_size,
    input  logic                               long_stream,
    input  logic                               binary_cls,
    input  logic                               loser_enc,
    input  logic [`CUT_DEPTH*`L1_CUT_W-1:0]    l1_cut_list,
    input  logic [`CUT_DEPTH*`L2_CUT_W-1:0]    l2_cut_list,
    input  logic [`CUT_IDX_W-1:0]              cut_last,
    output logic [`CMD_W-1:0]                  readback,
    output logic [`LED_W-1:0]                  led
);

    localparam int BLINK_CNT_W = $clog2(`BLINK_HALF_PERIOD + 1);
    localparam int NIB_W       = `LED_W / 2;

    logic [BLINK_CNT_W-1:0] blink_cnt;
    logic                   blink;
    logic [`L1_CUT_W-1:0]   l1_entry;
    logic [`L2_CUT_W-1:0]   l2_entry;
    logic [`LED_W-1:0]      led_pattern;
    logic                   cfg_state;

    // blink level, low out of reset
    always_ff @(posedge okClk) begin
        if (!reset_n) begin
            blink_cnt <= '0;
            blink     <= 1'b0;
        end else if (blink_cnt == BLINK_CNT_W'(`BLINK_HALF_PERIOD - 1)) begin
            blink_cnt <= '0;
            blink     <= ~blink;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // last written cut entries
    assign l1_entry  = l1_cut_list[cut_last*`L1_CUT_W +: `L1_CUT_W];
    assign l2_entry  = l2_cut_list[cut_last*`L2_CUT_W +: `L2_CUT_W];
    assign cfg_state = (state == ST_WORKLOAD_CONFIG) || (state == ST_CONFIG_DONE);

    // readback select and LED pattern, 1 means lit here
    always_comb begin
        readback    = '0;
        led_pattern = `LED_W'(state) & {`LED_W{blink}};
        if (state == ST_IDLE) begin
            led_pattern = {`LED_W{blink}};
        end else if (cfg_state && cmd_word != '0) begin
            if (cmd_word <= `CMD_W'(FLD_L2_CUT)) begin
                case (cfg_field_e'(cmd_word[3:0]))
                    FLD_ASIC_MODE:   readback = `CMD_W'(asic_mode);
                    FLD_TRAIN_EPOCH: readback = `CMD_W'(training_epochs);
                    FLD_INFER_EPOCH: readback = `CMD_W'(inference_epochs);
                    FLD_DATASET:     readback = `CMD_W'(dataset);
                    FLD_TIMESTEPS:   readback = `CMD_W'(timesteps);
                    FLD_INPUT_SIZE:  readback = `CMD_W'(input_size);
                    FLD_LONG_STREAM: readback = `CMD_W'(long_stream);
                    FLD_BINARY_CLS:  readback = `CMD_W'(binary_cls);
                    FLD_LOSER_ENC:   readback = `CMD_W'(loser_enc);
                    // cut entries are signed
                    FLD_L1_CUT: begin
                        readback = {{(`CMD_W-`L1_CUT_W){l1_entry[`L1_CUT_W-1]}}, l1_entry};
                    end
                    FLD_L2_CUT: begin
                        readback = {{(`CMD_W-`L2_CUT_W){l2_entry[`L2_CUT_W-1]}}, l2_entry};
                    end
                    default:         readback = '0;
                endcase
                led_pattern = readback[`LED_W-1:0];
            end else begin
                // bad select, nibbles blink in opposite phase
                led_pattern = {{NIB_W{blink}}, {NIB_W{~blink}}};
                readback    = `CMD_W'(led_pattern);
            end
        end
    end

    // active low drive, everything lit while in reset
    assign led = reset_n ? ~led_pattern : '0;

endmodule

/* hdl/workload_config_regs.sv */
`timescale 1ns/1ps

`include "bh_ctrl_settings.svh"

module workload_config_regs
    import bh_ctrl_pkg::*;
(
    input  logic                               okClk,
    input  logic                               reset_n,
    input  logic [`CMD_W-1:0]                  cmd_word,
    input  logic [`TRIG_W-1:0]                 trig,
    input  host_state_e                        state,
    output logic [1:0]                         asic_mode,
    output logic [`EPOCH_W-1:0]                training_epochs,
    output logic [`EPOCH_W-1:0]                inference_epochs,
    output logic [1:0]                         dataset,
    output logic [`EPOCH_W-1:0]                timesteps,
    output logic [`EPOCH_W-1:0]                input_size,
    output logic                               long_stream,
    output logic                               binary_cls,
    output logic                               loser_enc,
    output logic [`CUT_DEPTH*`L1_CUT_W-1:0]    l1_cut_list,
    output logic [`CUT_DEPTH*`L2_CUT_W-1:0]    l2_cut_list,
    output logic [`CUT_IDX_W-1:0]              cut_last
);

    // shared write pointer for both cut lists
    logic [`CUT_IDX_W-1:0] cut_idx;
    logic [`CUT_IDX_W-1:0] cut_idx_next;
    logic                  cut_wr;

    // either list write moves the pointer, only once if both fire
    assign cut_wr = trig[FLD_L1_CUT] | trig[FLD_L2_CUT];

    // wrap at the last entry
    assign cut_idx_next = (cut_idx == `CUT_IDX_W'(`CUT_DEPTH - 1)) ? '0 : cut_idx + 1'b1;

    always_ff @(posedge okClk) begin
        if (!reset_n) begin
            asic_mode        <= '0;
            training_epochs  <= '0;
            inference_epochs <= '0;
            dataset          <= '0;
            timesteps        <= '0;
            input_size       <= '0;
            long_stream      <= 1'b0;
            binary_cls       <= 1'b0;
            loser_enc        <= 1'b0;
            l1_cut_list      <= '0;
            l2_cut_list      <= '0;
            cut_idx          <= '0;
            cut_last         <= '0;
        end else if (state == ST_WORKLOAD_CONFIG) begin
            // each strobe loads its own field, several may fire at once
            if (trig[FLD_ASIC_MODE]) begin
                asic_mode <= cmd_word[1:0];
            end
            if (trig[FLD_TRAIN_EPOCH]) begin
                training_epochs <= cmd_word[`EPOCH_W-1:0];
            end
            if (trig[FLD_INFER_EPOCH]) begin
                inference_epochs <= cmd_word[`EPOCH_W-1:0];
            end
            if (trig[FLD_DATASET]) begin
                dataset <= cmd_word[1:0];
            end
            if (trig[FLD_TIMESTEPS]) begin
                timesteps <= cmd_word[`EPOCH_W-1:0];
            end
            if (trig[FLD_INPUT_SIZE]) begin
                input_size <= cmd_word[`EPOCH_W-1:0];
            end
            // single-bit mode flags
            if (trig[FLD_LONG_STREAM]) begin
                long_stream <= cmd_word[0];
            end
            if (trig[FLD_BINARY_CLS]) begin
                binary_cls <= cmd_word[0];
            end
            if (trig[FLD_LOSER_ENC]) begin
                loser_enc <= cmd_word[0];
            end
            // cut entries go to the current pointer
            if (trig[FLD_L1_CUT]) begin
                l1_cut_list[cut_idx*`L1_CUT_W +: `L1_CUT_W] <= cmd_word[`L1_CUT_W-1:0];
            end
            if (trig[FLD_L2_CUT]) begin
                l2_cut_list[cut_idx*`L2_CUT_W +: `L2_CUT_W] <= cmd_word[`L2_CUT_W-1:0];
            end
            if (cut_wr) begin
                cut_idx  <= cut_idx_next;
                // remembered for readback
                cut_last <= cut_idx;
            end
        end
    end

endmodule

/* tests/bh_ctrl_input.txt */
// first word is the vector count (hex), then one vector per line:
// cmd_word trig expected_readback expected_state check_mode
// check_mode 0 state only, 1 readback with its low byte on the LEDs,
// 2 readback with the state LED pattern, 3 bad select blink, 4 reset held
00000033
00000000 00000000 00000000 00000000 00000002
00000002 00000001 00000000 00000000 00000002
000000fa 00000020 00000000 00000000 00000002
00000001 00000001 00000000 00000001 00000001
00000005 00000000 00000000 00000001 00000001
00000000 00000000 00000000 00000001 00000002
00000003 00000001 00000000 00000001 00000001
0001a5c7 000003fe 00000000 00000001 00000003
00000001 00000000 00000003 00000001 00000001
00000002 00000000 0000a5c7 00000001 00000001
00000003 00000000 0000a5c7 00000001 00000001
00000004 00000000 00000003 00000001 00000001
00000005 00000000 0000a5c7 00000001 00000001
00000006 00000000 0000a5c7 00000001 00000001
00000007 00000000 00000001 00000001 00000001
00000008 00000000 00000001 00000001 00000001
00000009 00000000 00000001 00000001 00000001
00030310 00000040 00000000 00000001 00000003
00000006 00000000 00000310 00000001 00000001
00000002 00000200 0000a5c7 00000001 00000001
00000009 00000000 00000000 00000001 00000001
0000000c 00000000 00000000 00000001 00000003
00018001 00000400 00000000 00000001 00000000
0000000a 00000400 0000000a 00000001 00000001
00000101 00000c00 00000000 00000001 00000000
00000102 00000400 00000000 00000001 00000000
00000103 00000800 00000000 00000001 00000000
00000104 00000400 00000000 00000001 00000000
00000105 00000400 00000000 00000001 00000000
00000106 00000c00 00000000 00000001 00000000
00000107 00000400 00000000 00000001 00000000
00000108 00000400 00000000 00000001 00000000
00000109 00000800 00000000 00000001 00000000
0000010a 00000400 00000000 00000001 00000000
0000010b 00000400 00000000 00000001 00000000
0000010c 00000400 00000000 00000001 00000000
0000000b 00000c00 0000000b 00000001 00000001
00017ffe 00000c00 00000000 00000001 00000000
0000000a 00000000 ffff7ffe 00000001 00000001
0000000b 00000000 00007ffe 00000001 00000001
00000002 00000001 0000a5c7 00000002 00000001
00000001 00000002 00000003 00000002 00000001
00000005 00000001 0000a5c7 00000002 00000001
00000003 00000001 00000000 00000003 00000002
00000007 00000001 00000000 00000003 00000002
00000000 00000000 00000000 00000000 00000004
00000001 00000001 00000000 00000001 00000001
0000000a 00000000 00000000 00000001 00000001
00000002 00000001 00000000 00000002 00000001
00000007 00000001 00000000 00000007 00000002
00000000 00000000 00000000 00000007 00000002

/* tests/bh_ctrl_props.sv */
`timescale 1ns/1ps

`include "bh_ctrl_settings.svh"

module bh_ctrl_props
    import bh_ctrl_pkg::*;
#(
    // every register of the settings bank, cut_last included
    parameter int FIELD_W = 4 + 4*`EPOCH_W + 3 + `CUT_DEPTH*(`L1_CUT_W + `L2_CUT_W) + `CUT_IDX_W
) (
    input logic                  okClk,
    input logic                  reset_n,
    input logic [`TRIG_W-1:0]    trig,
    input host_state_e           state,
    input logic [`CUT_IDX_W-1:0] cut_last,
    input logic [FIELD_W-1:0]    fields
);

    int assert_fails = 0;

    // no step strobe, no state move
    state_needs_step: assert property (
        @(posedge okClk) disable iff (!reset_n) !trig[0] |=> $stable(state)
    ) else begin
        assert_fails++;
        $error("state changed without trigger bit 0");
    end

    cut_last_in_range: assert property (
        @(posedge okClk) disable iff (!reset_n) cut_last < `CUT_IDX_W'(`CUT_DEPTH)
    ) else begin
        assert_fails++;
        $error("cut_last %0d is past the last cut entry", cut_last);
    end

    // bank frozen outside workload config
    fields_only_in_config: assert property (
        @(posedge okClk) disable iff (!reset_n)
            state != ST_WORKLOAD_CONFIG |=> $stable(fields)
    ) else begin
        assert_fails++;
        $error("a workload field changed outside workload config");
    end

endmodule

bind workload_config_regs bh_ctrl_props u_props (
    .okClk    (okClk),
    .reset_n  (reset_n),
    .trig     (trig),
    .state    (state),
    .cut_last (cut_last),
    .fields   ({asic_mode, training_epochs, inference_epochs, dataset, timesteps,
                input_size, long_stream, binary_cls, loser_enc, l1_cut_list,
                l2_cut_list, cut_last})
);

/* tests/tb_bh_ctrl.sv */
`timescale 1ns/1ps

`include "bh_ctrl_settings.svh"

module tb_bh_ctrl;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_VEC      = 64;
    // words per vector line in the data file
    localparam int VEC_WORDS    = 5;

    logic               okClk;
    logic               reset_n;
    logic [`CMD_W-1:0]  cmd_word;
    logic [`TRIG_W-1:0] trig;
    logic [`CMD_W-1:0]  readback;
    logic [`CMD_W-1:0]  state_word;
    logic [`LED_W-1:0]  led;

    // word 0 holds the vector count and five words per vector follow
    logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS];
    int          num_vec;
    int          errors;
    int          checks;
    int          rise_cnt;
    int          assert_errors;
    bit          vec_loaded;

    bh_ctrl_top dut0 (
        .okClk      (okClk),
        .reset_n    (reset_n),
        .cmd_word   (cmd_word),
        .trig       (trig),
        .readback   (readback),
        .state_word (state_word),
        .led        (led)
    );

    always #(CLK_PERIOD/2) okClk = ~okClk;

    // rising edges since reset release for the blink model
    always @(posedge okClk) begin
        if (!reset_n) begin
            rise_cnt <= 0;
        end else begin
            rise_cnt <= rise_cnt + 1;
        end
    end

    // blink starts low and flips every half period after release
    function automatic bit blink_level();
        return ((rise_cnt / `BLINK_HALF_PERIOD) % 2) == 1;
    endfunction

    // active-low LEDs outside a field readback
    function automatic logic [`LED_W-1:0] state_led(input logic [3:0] code);
        logic [`LED_W-1:0] lit;
        if (code == 4'd0) begin
            // idle blinks every LED
            lit = {`LED_W{blink_level()}};
        end else begin
            lit = `LED_W'(code) & {`LED_W{blink_level()}};
        end
        return ~lit;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // drive one vector on the falling edge and check on the next one
    task automatic apply_vector(input int idx);
        logic [31:0]       cmd;
        logic [31:0]       trg;
        logic [31:0]       exp_rb;
        logic [31:0]       exp_st;
        logic [31:0]       mode;
        logic [`LED_W-1:0] led_exp;
        logic [`LED_W-1:0] pattern;
        bit                b;
        int                base;
        base   = 1 + idx * VEC_WORDS;
        cmd    = vec_mem[base];
        trg    = vec_mem[base+1];
        exp_rb = vec_mem[base+2];
        exp_st = vec_mem[base+3];
        mode   = vec_mem[base+4];
        // without a strobe and outside config nothing reads cmd_word
        if (trg == '0 && exp_st != 32'd1 && exp_st != 32'd2) begin
            cmd = $urandom;
        end
        cmd_word = cmd;
        trig     = trg;
        reset_n  = (mode != 32'd4);
        @(negedge okClk);
        check_value("state_word", state_word, exp_st);
        case (mode)
            // field readback with its low byte on the LEDs
            32'd1: begin
                led_exp = ~exp_rb[`LED_W-1:0];
                check_value("readback", readback, exp_rb);
                check_value("led", 32'(led), 32'(led_exp));
            end
            32'd2: begin
                led_exp = state_led(exp_st[3:0]);
                check_value("readback", readback, exp_rb);
                check_value("led", 32'(led), 32'(led_exp));
            end
            // bad select blinks the nibbles in opposite phase
            32'd3: begin
                b       = blink_level();
                pattern = {{(`LED_W/2){b}}, {(`LED_W/2){~b}}};
                led_exp = ~pattern;
                check_value("readback on bad select", readback, 32'(pattern));
                check_value("led on bad select", 32'(led), 32'(led_exp));
            end
            32'd4: begin
                check_value("readback in reset", readback, exp_rb);
                check_value("led in reset", 32'(led), 32'd0);
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        okClk         = 1'b0;
        reset_n       = 1'b0;
        cmd_word      = '0;
        trig          = '0;
        errors        = 0;
        checks        = 0;
        assert_errors = 0;
        vec_loaded    = 1'b0;
        // seed the generator once
        void'($urandom(32'h3c87_c49a));
        $readmemh("tests/bh_ctrl_input.txt", vec_mem);
        num_vec = int'(vec_mem[0]);
        if (num_vec < 1 || num_vec > MAX_VEC) begin
            $display("vector file gave a count of %0d, no vectors were run", num_vec);
            errors++;
        end else begin
            vec_loaded = 1'b1;
            repeat (RESET_CYCLES) @(negedge okClk);
            // still inside reset here
            check_value("state_word in reset", state_word, 32'd0);
            check_value("readback in reset", readback, 32'd0);
            check_value("led in reset", 32'(led), 32'd0);
            reset_n = 1'b1;
            for (int i = 0; i < num_vec; i++) begin
                apply_vector(i);
            end
        end
        assert_errors = dut0.u_cfg.u_props.assert_fails;
        $display("%0d vectors, %0d checks, %0d value errors, %0d assertion failures",
                 num_vec, checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog at four times the expected run length
    initial begin
        wait (vec_loaded);
        #((num_vec + RESET_CYCLES) * CLK_PERIOD * 4);
        $display("watchdog expired before all vectors were applied");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
